/* source/cpuPkg.sv */
// Widths, opcodes and bus structs shared by the core and its AXI4-Lite host block
// Widths are fixed by the 16-bit instruction format
`default_nettype none

package cpuPkg;

  localparam int DataWidth = 16;
  localparam int MemAddrWidth = 8;
  localparam int RegCount = 4;
  localparam int RegIdxWidth = $clog2(RegCount);
  localparam int AxiAddrWidth = 12;
  localparam int AxiDataWidth = 32;

  // Opcode numbers from IR[15:10], any other value is a no-op
  typedef enum logic [5:0] {
    opBra = 6'd0,
    opBne = 6'd1,
    opBeq = 6'd2,
    opLsl = 6'd7,
    opLsr = 6'd8,
    opNot = 6'd14,
    opMovl = 6'd17,
    opLd = 6'd18,
    opSt = 6'd19,
    opAdd = 6'd21,
    opSub = 6'd23,
    opAnd = 6'd27,
    opOrr = 6'd28,
    opXor = 6'd29,
    opHlt = 6'd63
  } opcode_t;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOrr, aluXor, aluNot, aluLsl, aluLsr
  } aluOp_t;

  typedef enum logic [1:0] {
    wbAlu, wbImm, wbMemLow, wbMemHigh
  } wbSource_t;

  typedef enum logic [2:0] {
    stIdle, stFetchLow, stFetchHigh, stExecLow, stExecHigh, stHalted
  } seqState_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } aluFlags_t;

  typedef struct packed {
    logic regWrite;
    logic [RegIdxWidth-1:0] regDest;
    wbSource_t wbSource;
    aluOp_t aluOp;
    logic [RegIdxWidth-1:0] srcA;
    logic [RegIdxWidth-1:0] srcB;
    logic flagUpdate;
  } controlWord_t;

  typedef struct packed {
    logic write;
    logic [MemAddrWidth-1:0] addr;
    logic [DataWidth-1:0] storeWord;
    logic highByte;
  } coreMemReq_t;

  typedef struct packed {
    logic write;
    logic [MemAddrWidth-1:0] addr;
    logic [7:0] wrByte;
  } hostMemReq_t;

  typedef struct packed {
    logic [AxiAddrWidth-1:0] awaddr;
    logic awvalid;
    logic [AxiDataWidth-1:0] wdata;
    logic [AxiDataWidth/8-1:0] wstrb;
    logic wvalid;
    logic bready;
    logic [AxiAddrWidth-1:0] araddr;
    logic arvalid;
    logic rready;
  } axiLiteReq_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [AxiDataWidth-1:0] rdata;
    logic [1:0] rresp;
  } axiLiteRsp_t;

  typedef logic [RegCount-1:0][DataWidth-1:0] regView_t;

endpackage

`default_nettype wire

/* source/aluUnit.sv */
// Combinational result, registered flags; NOT and the shifts use operand A only
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  wire logic Clock,
  input  wire logic rstN,
  input  wire cpuPkg::controlWord_t ctrl,
  input  wire logic [cpuPkg::DataWidth-1:0] operandA,
  input  wire logic [cpuPkg::DataWidth-1:0] operandB,
  output logic [cpuPkg::DataWidth-1:0] result,
  output cpuPkg::aluFlags_t flags
);
  import cpuPkg::*;

  logic carryOut;

  always_comb begin
    result = '0;
    carryOut = 1'b0;
    case (ctrl.aluOp)
      aluAdd: {carryOut, result} = {1'b0, operandA} + {1'b0, operandB};
      // Carry of A plus inverted B plus one
      aluSub: {carryOut, result} = {1'b0, operandA} + {1'b0, ~operandB} + 1'b1;
      aluAnd: result = operandA & operandB;
      aluOrr: result = operandA | operandB;
      aluXor: result = operandA ^ operandB;
      aluNot: result = ~operandA;
      aluLsl: {carryOut, result} = {operandA, 1'b0};
      aluLsr: {result, carryOut} = {1'b0, operandA};
      default: begin
      end
    endcase
  end

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      flags <= '0;
    end else if (ctrl.flagUpdate) begin
      flags.zero <= result == '0;
      flags.negative <= result[DataWidth-1];
      flags.carry <= carryOut;
    end
  end

endmodule

`default_nettype wire

/* source/byteMemory.sv */
// Combinational reads; a core store wins over a host write in the same cycle
`timescale 1ns/1ps
`default_nettype none

module byteMemory (
  input  wire logic Clock,
  input  wire cpuPkg::coreMemReq_t coreMem,
  input  wire cpuPkg::hostMemReq_t hostMem,
  input  wire logic [cpuPkg::MemAddrWidth-1:0] hostRdAddr,
  output logic [7:0] coreRdData,
  output logic [7:0] hostRdData
);
  import cpuPkg::*;

  logic [7:0] mem [2**MemAddrWidth];

  assign coreRdData = mem[coreMem.addr];
  assign hostRdData = mem[hostRdAddr];

  always_ff @(posedge Clock) begin
    if (coreMem.write) begin
      mem[coreMem.addr] <= coreMem.highByte ? coreMem.storeWord[15:8] : coreMem.storeWord[7:0];
    end else if (hostMem.write) begin
      mem[hostMem.addr] <= hostMem.wrByte;
    end
  end

endmodule

`default_nettype wire

/* source/registerFile.sv */
// R1 to R4 at indices 0 to 3; a memory byte replaces one half of the destination
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  wire logic Clock,
  input  wire logic rstN,
  input  wire cpuPkg::controlWord_t ctrl,
  input  wire logic [cpuPkg::DataWidth-1:0] aluResult,
  input  wire logic [7:0] rdByte,
  output logic [cpuPkg::DataWidth-1:0] operandA,
  output logic [cpuPkg::DataWidth-1:0] operandB,
  output cpuPkg::regView_t regView
);
  import cpuPkg::*;

  regView_t regs;
  logic [DataWidth-1:0] destValue;
  logic [DataWidth-1:0] wbData;

  assign destValue = regs[ctrl.regDest];
  assign operandA = regs[ctrl.srcA];
  assign operandB = regs[ctrl.srcB];
  assign regView = regs;

  always_comb begin
    case (ctrl.wbSource)
      wbImm: wbData = {8'h00, rdByte};
      wbMemLow: wbData = {destValue[15:8], rdByte};
      wbMemHigh: wbData = {rdByte, destValue[7:0]};
      default: wbData = aluResult;
    endcase
  end

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      regs <= '0;
    end else if (ctrl.regWrite) begin
      regs[ctrl.regDest] <= wbData;
    end
  end

endmodule

`default_nettype wire

/* source/sequenceController.sv */
// Multi-cycle control: two fetch cycles, then one execute cycle or two for LD and ST
// Branch targets and memory addresses are absolute 8-bit values from IR[7:0]
`timescale 1ns/1ps
`default_nettype none

module sequenceController (
  input  wire logic Clock,
  input  wire logic rstN,
  input  wire logic start,
  input  wire logic [7:0] rdByte,
  input  wire cpuPkg::aluFlags_t flags,
  output cpuPkg::controlWord_t ctrl,
  output cpuPkg::coreMemReq_t coreMem,
  output logic busy,
  output logic halted
);
  import cpuPkg::*;

  seqState_t state;
  logic [MemAddrWidth-1:0] pc;
  logic [7:0] irLow;
  logic [7:0] irHigh;
  logic [DataWidth-1:0] ir;
  opcode_t opcode;
  logic branchTaken;

  function automatic aluOp_t toAluOp(input opcode_t op);
    case (op)
      opSub: return aluSub;
      opAnd: return aluAnd;
      opOrr: return aluOrr;
      opXor: return aluXor;
      opNot: return aluNot;
      opLsl: return aluLsl;
      opLsr: return aluLsr;
      default: return aluAdd;
    endcase
  endfunction

  assign ir = {irHigh, irLow};
  assign opcode = opcode_t'(ir[15:10]);
  assign busy = !(state == stIdle || state == stHalted);
  assign halted = state == stHalted;
  assign branchTaken = opcode == opBra
                    || (opcode == opBne && !flags.zero)
                    || (opcode == opBeq && flags.zero);

  always_comb begin
    ctrl = '0;
    coreMem = '0;
    coreMem.addr = pc;
    if (state == stExecLow) begin
      case (opcode)
        opMovl: begin
          // Immediate is re-read from the instruction's low byte
          coreMem.addr = pc - 8'd2;
          ctrl.regWrite = 1'b1;
          ctrl.regDest = ir[9:8];
          ctrl.wbSource = wbImm;
        end
        opLd: begin
          coreMem.addr = ir[7:0];
          ctrl.regWrite = 1'b1;
          ctrl.regDest = ir[9:8];
          ctrl.wbSource = wbMemLow;
        end
        opSt: begin
          coreMem.write = 1'b1;
          coreMem.addr = ir[7:0];
          ctrl.srcA = ir[9:8];
        end
        opAdd, opSub, opAnd, opOrr, opXor, opNot, opLsl, opLsr: begin
          ctrl.regWrite = 1'b1;
          ctrl.regDest = ir[7:6];
          ctrl.wbSource = wbAlu;
          ctrl.aluOp = toAluOp(opcode);
          ctrl.srcA = ir[4:3];
          ctrl.srcB = ir[1:0];
          ctrl.flagUpdate = ir[9];
        end
        default: begin
        end
      endcase
    end else if (state == stExecHigh) begin
      coreMem.addr = ir[7:0] + 8'd1;
      if (opcode == opLd) begin
        ctrl.regWrite = 1'b1;
        ctrl.regDest = ir[9:8];
        ctrl.wbSource = wbMemHigh;
      end else begin
        coreMem.write = 1'b1;
        coreMem.highByte = 1'b1;
        ctrl.srcA = ir[9:8];
      end
    end
  end

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      state <= stIdle;
      pc <= '0;
    end else begin
      case (state)
        stIdle, stHalted: begin
          if (start) begin
            pc <= '0;
            state <= stFetchLow;
          end
        end
        stFetchLow: begin
          pc <= pc + 8'd1;
          state <= stFetchHigh;
        end
        stFetchHigh: begin
          pc <= pc + 8'd1;
          state <= stExecLow;
        end
        stExecLow: begin
          if (opcode == opLd || opcode == opSt) begin
            state <= stExecHigh;
          end else if (opcode == opHlt) begin
            state <= stHalted;
          end else begin
            state <= stFetchLow;
          end
          if (branchTaken) begin
            pc <= ir[7:0];
          end
        end
        stExecHigh: state <= stFetchLow;
        default: state <= stIdle;
      endcase
    end
  end

  // Low byte arrives first
  always_ff @(posedge Clock) begin
    if (state == stFetchLow) begin
      irLow <= rdByte;
    end
    if (state == stFetchHigh) begin
      irHigh <= rdByte;
    end
  end

endmodule

`default_nettype wire

/* source/hostConfigRegs.sv */
// AXI4-Lite slave, one write and one read outstanding; memory writes and starts
// while the core is busy get SLVERR and have no effect
`timescale 1ns/1ps
`default_nettype none

module hostConfigRegs (
  input  wire logic Clock,
  input  wire logic rstN,
  input  wire cpuPkg::axiLiteReq_t axiReq,
  output cpuPkg::axiLiteRsp_t axiRsp,
  input  wire logic busy,
  input  wire logic halted,
  input  wire cpuPkg::aluFlags_t flags,
  input  wire cpuPkg::regView_t regView,
  input  wire logic [7:0] hostRdData,
  output logic start,
  output cpuPkg::hostMemReq_t hostMem
);
  import cpuPkg::*;

  localparam logic [1:0] RespOkay = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  logic wrAccept;
  logic rdAccept;
  logic bValid;
  logic rValid;
  logic [1:0] bResp;
  logic [1:0] rResp;
  logic [AxiDataWidth-1:0] rData;
  logic wrReq;
  logic rdReq;
  logic wrIsCtrl;
  logic wrIsMem;
  logic startBit;
  logic wrErr;
  logic rdErr;
  logic [AxiDataWidth-1:0] rdValue;

  // A write takes priority so the shared memory address has one owner
  assign wrReq = axiReq.awvalid && axiReq.wvalid && !wrAccept && !bValid;
  assign rdReq = axiReq.arvalid && !rdAccept && !rValid && !wrReq;

  assign wrIsCtrl = axiReq.awaddr == 12'h000;
  assign wrIsMem = axiReq.awaddr[11:8] == 4'h1;
  assign startBit = axiReq.wdata[0] && axiReq.wstrb[0];
  assign wrErr = !(wrIsCtrl || wrIsMem) || (busy && (wrIsMem || startBit));

  assign start = wrAccept && wrIsCtrl && startBit && !busy;
  assign hostMem.write = wrAccept && wrIsMem && axiReq.wstrb[0] && !busy;
  assign hostMem.addr = wrAccept ? axiReq.awaddr[7:0] : axiReq.araddr[7:0];
  assign hostMem.wrByte = axiReq.wdata[7:0];

  always_comb begin
    rdErr = 1'b0;
    rdValue = '0;
    if (axiReq.araddr == 12'h004) begin
      rdValue = {25'd0, flags.carry, flags.negative, flags.zero, 2'b00, halted, busy};
    end else if (axiReq.araddr[11:4] == 8'h01 && axiReq.araddr[1:0] == 2'b00) begin
      rdValue = {16'h0000, regView[axiReq.araddr[3:2]]};
    end else if (axiReq.araddr[11:8] == 4'h1) begin
      rdValue = {24'd0, hostRdData};
    end else begin
      rdErr = 1'b1;
    end
  end

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      wrAccept <= 1'b0;
      rdAccept <= 1'b0;
      bValid <= 1'b0;
      rValid <= 1'b0;
      bResp <= RespOkay;
      rResp <= RespOkay;
    end else begin
      wrAccept <= wrReq;
      rdAccept <= rdReq;
      if (wrAccept) begin
        bValid <= 1'b1;
        bResp <= wrErr ? RespSlvErr : RespOkay;
      end else if (bValid && axiReq.bready) begin
        bValid <= 1'b0;
      end
      if (rdAccept) begin
        rValid <= 1'b1;
        rResp <= rdErr ? RespSlvErr : RespOkay;
      end else if (rValid && axiReq.rready) begin
        rValid <= 1'b0;
      end
    end
  end

  // Read data is captured in the address phase and held while rvalid waits
  always_ff @(posedge Clock) begin
    if (rdAccept) begin
      rData <= rdValue;
    end
  end

  assign axiRsp.awready = wrAccept;
  assign axiRsp.wready = wrAccept;
  assign axiRsp.bvalid = bValid;
  assign axiRsp.bresp = bResp;
  assign axiRsp.arready = rdAccept;
  assign axiRsp.rvalid = rValid;
  assign axiRsp.rdata = rData;
  assign axiRsp.rresp = rResp;

endmodule

`default_nettype wire

/* source/cpuTop.sv */
// Core plus AXI4-Lite host block; the host loads memory only while the core is idle or halted
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
  input  wire logic Clock,
  input  wire logic rstN,
  input  wire cpuPkg::axiLiteReq_t axiReq,
  output cpuPkg::axiLiteRsp_t axiRsp
);
  import cpuPkg::*;

  logic start;
  logic busy;
  logic halted;
  aluFlags_t flags;
  regView_t regView;
  controlWord_t ctrl;
  coreMemReq_t ctrlMem;
  coreMemReq_t coreMem;
  hostMemReq_t hostMem;
  logic [7:0] coreRdData;
  logic [7:0] hostRdData;
  logic [DataWidth-1:0] operandA;
  logic [DataWidth-1:0] operandB;
  logic [DataWidth-1:0] aluResult;

  // Store word is register operand A
  assign coreMem = '{
    write: ctrlMem.write,
    addr: ctrlMem.addr,
    storeWord: operandA,
    highByte: ctrlMem.highByte
  };

  hostConfigRegs u_hostConfigRegs (
    .Clock(Clock),
    .rstN(rstN),
    .axiReq(axiReq),
    .axiRsp(axiRsp),
    .busy(busy),
    .halted(halted),
    .flags(flags),
    .regView(regView),
    .hostRdData(hostRdData),
    .start(start),
    .hostMem(hostMem)
  );

  sequenceController u_sequenceController (
    .Clock(Clock),
    .rstN(rstN),
    .start(start),
    .rdByte(coreRdData),
    .flags(flags),
    .ctrl(ctrl),
    .coreMem(ctrlMem),
    .busy(busy),
    .halted(halted)
  );

  registerFile u_registerFile (
    .Clock(Clock),
    .rstN(rstN),
    .ctrl(ctrl),
    .aluResult(aluResult),
    .rdByte(coreRdData),
    .operandA(operandA),
    .operandB(operandB),
    .regView(regView)
  );

  aluUnit u_aluUnit (
    .Clock(Clock),
    .rstN(rstN),
    .ctrl(ctrl),
    .operandA(operandA),
    .operandB(operandB),
    .result(aluResult),
    .flags(flags)
  );

  byteMemory u_byteMemory (
    .Clock(Clock),
    .coreMem(coreMem),
    .hostMem(hostMem),
    .hostRdAddr(hostMem.addr),
    .coreRdData(coreRdData),
    .hostRdData(hostRdData)
  );

endmodule

`default_nettype wire

/* verif/hostBus_assertions.sv */
// Bound to hostConfigRegs; checks the AXI4-Lite response handshake and run status
`timescale 1ns/1ps
`default_nettype none

module hostBus_assertions (
  input wire logic Clock,
  input wire logic rstN,
  input wire cpuPkg::axiLiteReq_t axiReq,
  input wire cpuPkg::axiLiteRsp_t axiRsp,
  input wire logic busy,
  input wire logic halted
);

  bvalidHold: assert property (@(posedge Clock) disable iff (!rstN)
    axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalidHold: assert property (@(posedge Clock) disable iff (!rstN)
    axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
    else $error("rvalid dropped before rready");

  rdataStable: assert property (@(posedge Clock) disable iff (!rstN)
    axiRsp.rvalid && !axiReq.rready |=> $stable(axiRsp.rdata))
    else $error("rdata changed while rvalid waited");

  awreadyWithValid: assert property (@(posedge Clock) disable iff (!rstN)
    axiRsp.awready |-> axiReq.awvalid && axiReq.wvalid)
    else $error("awready without awvalid and wvalid");

  busyOrHalted: assert property (@(posedge Clock) disable iff (!rstN)
    !(busy && halted))
    else $error("busy and halted both high");

endmodule

bind hostConfigRegs hostBus_assertions u_hostBusAssertions (.*);

`default_nettype wire

/* include/cpuTbModel.svh */
// Instruction encoders and the ISA reference model; include inside a module
// The model stops at HLT or after maxSteps instructions
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

typedef struct {
  logic [15:0] regs [4];
  cpuPkg::aluFlags_t flags;
  logic [7:0] mem [256];
  bit halted;
} modelResult_t;

// ALU format: op, flag update, dest IR[7:6], A IR[4:3], B IR[1:0]
function automatic logic [15:0] encAlu(input cpuPkg::opcode_t op, input bit flagUpd,
                                       input logic [1:0] dest, srcA, srcB);
  return {op, flagUpd, 1'b0, dest, 1'b0, srcA, 1'b0, srcB};
endfunction

// MOVL, LD, ST and branches
function automatic logic [15:0] encImm(input cpuPkg::opcode_t op, input logic [1:0] reg_,
                                       input logic [7:0] imm);
  return {op, reg_, imm};
endfunction

function automatic bit modelAlu(input cpuPkg::opcode_t op, input logic [15:0] a, b,
                                output logic [15:0] y, output logic c);
  y = '0;
  c = 1'b0;
  case (op)
    cpuPkg::opAdd: {c, y} = {1'b0, a} + {1'b0, b};
    cpuPkg::opSub: {c, y} = {1'b0, a} + {1'b0, ~b} + 1'b1;
    cpuPkg::opAnd: y = a & b;
    cpuPkg::opOrr: y = a | b;
    cpuPkg::opXor: y = a ^ b;
    cpuPkg::opNot: y = ~a;
    cpuPkg::opLsl: {c, y} = {a, 1'b0};
    cpuPkg::opLsr: {y, c} = {1'b0, a};
    default: return 1'b0;
  endcase
  return 1'b1;
endfunction

function automatic modelResult_t runModel(input logic [7:0] image [256], input int maxSteps);
  modelResult_t res;
  logic [7:0] pc;
  logic [7:0] arg;
  logic [15:0] ir;
  logic [15:0] y;
  logic c;
  cpuPkg::opcode_t op;
  res.mem = image;
  foreach (res.regs[i]) res.regs[i] = '0;
  res.flags = '0;
  res.halted = 1'b0;
  pc = '0;
  for (int step = 0; step < maxSteps && !res.halted; step++) begin
    ir = {res.mem[pc + 8'd1], res.mem[pc]};
    pc = pc + 8'd2;
    arg = ir[7:0];
    op = cpuPkg::opcode_t'(ir[15:10]);
    case (op)
      cpuPkg::opHlt: res.halted = 1'b1;
      cpuPkg::opBra: pc = arg;
      cpuPkg::opBne: if (!res.flags.zero) pc = arg;
      cpuPkg::opBeq: if (res.flags.zero) pc = arg;
      cpuPkg::opMovl: res.regs[ir[9:8]] = {8'h00, arg};
      cpuPkg::opLd: begin
        res.regs[ir[9:8]][7:0] = res.mem[arg];
        res.regs[ir[9:8]][15:8] = res.mem[arg + 8'd1];
      end
      cpuPkg::opSt: begin
        res.mem[arg] = res.regs[ir[9:8]][7:0];
        res.mem[arg + 8'd1] = res.regs[ir[9:8]][15:8];
      end
      default: begin
        if (modelAlu(op, res.regs[ir[4:3]], res.regs[ir[1:0]], y, c)) begin
          res.regs[ir[7:6]] = y;
          if (ir[9]) res.flags = '{zero: y == 16'h0000, negative: y[15], carry: c};
        end
      end
    endcase
  end
  return res;
endfunction

`endif

/* verif/cpuTb.sv */
// Drives cpuTop over AXI4-Lite and checks each run against the ISA model.
// Start clears only PC, so every program sets R1 to R4 and updates the flags before use.
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  `include "cpuTbModel.svh"

  localparam int WaitLimit = 50;
  localparam int RunLimit = 500;
  localparam int ModelSteps = 1000;
  localparam logic [1:0] RespOkay = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;
  localparam logic [11:0] CtrlAddr = 12'h000;
  localparam logic [11:0] StatusAddr = 12'h004;
  localparam logic [11:0] RegBase = 12'h010;
  localparam logic [11:0] MemBase = 12'h100;

  logic Clock;
  logic rstN;
  axiLiteReq_t axiReq;
  axiLiteRsp_t axiRsp;

  logic [7:0] image [256];
  logic [7:0] dutMem [256];
  bit memKnown;
  int progLen;
  modelResult_t refState;

  logic [31:0] gotQ [$];
  logic [31:0] expQ [$];
  string whatQ [$];
  int checkCount;
  int valueErrors;
  int protoErrors;

  cpuTop u_dut (
    .Clock(Clock),
    .rstN(rstN),
    .axiReq(axiReq),
    .axiRsp(axiRsp)
  );

  initial begin
    Clock = 1'b0;
    forever #20 Clock = ~Clock;
  end

  task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int cycles;
    @(posedge Clock);
    axiReq.awaddr <= addr;
    axiReq.awvalid <= 1'b1;
    axiReq.wdata <= data;
    axiReq.wstrb <= 4'hf;
    axiReq.wvalid <= 1'b1;
    cycles = 0;
    do begin
      @(posedge Clock);
      cycles++;
    end while (!(axiRsp.awready && axiRsp.wready) && cycles < WaitLimit);
    assert (axiRsp.awready && axiRsp.wready) else begin
      protoErrors++;
      $display("Timeout: write to 0x%h was never accepted", addr);
    end
    axiReq.awvalid <= 1'b0;
    axiReq.wvalid <= 1'b0;
    cycles = 0;
    do begin
      @(posedge Clock);
      cycles++;
    end while (!axiRsp.bvalid && cycles < WaitLimit);
    assert (axiRsp.bvalid) else begin
      protoErrors++;
      $display("Timeout: no write response for 0x%h", addr);
    end
    resp = axiRsp.bresp;
    // Response accepted one cycle after it shows up, so bvalid has to hold
    axiReq.bready <= 1'b1;
    @(posedge Clock);
    axiReq.bready <= 1'b0;
  endtask

  task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int cycles;
    @(posedge Clock);
    axiReq.araddr <= addr;
    axiReq.arvalid <= 1'b1;
    cycles = 0;
    do begin
      @(posedge Clock);
      cycles++;
    end while (!axiRsp.arready && cycles < WaitLimit);
    assert (axiRsp.arready) else begin
      protoErrors++;
      $display("Timeout: read of 0x%h was never accepted", addr);
    end
    axiReq.arvalid <= 1'b0;
    cycles = 0;
    do begin
      @(posedge Clock);
      cycles++;
    end while (!axiRsp.rvalid && cycles < WaitLimit);
    assert (axiRsp.rvalid) else begin
      protoErrors++;
      $display("Timeout: no read data for 0x%h", addr);
    end
    data = axiRsp.rdata;
    resp = axiRsp.rresp;
    // Data accepted one cycle late, so rvalid and rdata have to hold
    axiReq.rready <= 1'b1;
    @(posedge Clock);
    axiReq.rready <= 1'b0;
  endtask

  function automatic void expectValue(input string what, input logic [31:0] got,
                                      input logic [31:0] exp);
    gotQ.push_back(got);
    expQ.push_back(exp);
    whatQ.push_back(what);
  endfunction

  function automatic void expectResp(input string what, input logic [1:0] got,
                                     input logic [1:0] exp);
    assert (got === exp) else begin
      protoErrors++;
      $display("Bad response: %s answered %b instead of %b", what, got, exp);
    end
  endfunction

  // Compares every queued readback with its expected value
  initial begin : compareProcess
    logic [31:0] got;
    logic [31:0] exp;
    string what;
    forever begin
      @(posedge Clock);
      while (gotQ.size() > 0) begin
        got = gotQ.pop_front();
        exp = expQ.pop_front();
        what = whatQ.pop_front();
        checkCount++;
        assert (got === exp) else begin
          valueErrors++;
          $display("Fail at %0d ns: %s read 0x%h, expected 0x%h", $time, what, got, exp);
        end
      end
    end
  end

  task automatic drainChecks();
    int cycles;
    cycles = 0;
    while (gotQ.size() > 0 && cycles < WaitLimit) begin
      @(posedge Clock);
      cycles++;
    end
    assert (gotQ.size() == 0) else begin
      protoErrors++;
      $display("Timeout: comparison queue still holds %0d entries", gotQ.size());
    end
  endtask

  function automatic void newImage();
    for (int a = 0; a < 256; a++) begin
      image[a] = 8'(a * 73) ^ 8'(a >> 3) ^ 8'h5a;
    end
    progLen = 0;
  endfunction

  function automatic void emit(input logic [15:0] word);
    image[progLen] = word[7:0];
    image[progLen + 1] = word[15:8];
    progLen += 2;
  endfunction

  // Only bytes that differ from the known memory contents are rewritten
  task automatic loadImage();
    logic [1:0] resp;
    for (int a = 0; a < 256; a++) begin
      if (!memKnown || image[a] !== dutMem[a]) begin
        axiWrite(MemBase + 12'(a), {24'd0, image[a]}, resp);
        expectResp($sformatf("memory write 0x%02h", a), resp, RespOkay);
        dutMem[a] = image[a];
      end
    end
    memKnown = 1'b1;
  endtask

  task automatic startRun();
    logic [1:0] resp;
    axiWrite(CtrlAddr, 32'h1, resp);
    expectResp("start", resp, RespOkay);
  endtask

  task automatic waitHalted();
    logic [31:0] status;
    logic [1:0] resp;
    int polls;
    polls = 0;
    do begin
      axiRead(StatusAddr, status, resp);
      polls++;
    end while (status[0] !== 1'b0 && polls < RunLimit);
    assert (status[0] === 1'b0 && status[1] === 1'b1) else begin
      protoErrors++;
      $display("Timeout: core did not halt within %0d status polls", polls);
    end
  endtask

  task automatic checkState(input string name);
    logic [31:0] data;
    logic [31:0] expStatus;
    logic [1:0] resp;
    refState = runModel(image, ModelSteps);
    assert (refState.halted) else begin
      protoErrors++;
      $display("Reference model never reached HLT in %s", name);
    end
    for (int r = 0; r < 4; r++) begin
      axiRead(RegBase + 12'(4 * r), data, resp);
      expectResp($sformatf("%s R%0d read", name, r + 1), resp, RespOkay);
      expectValue($sformatf("%s R%0d", name, r + 1), data, {16'h0000, refState.regs[r]});
    end
    // Halted, not busy, flags in bits 4 to 6
    expStatus = 32'h0000_0002;
    expStatus[4] = refState.flags.zero;
    expStatus[5] = refState.flags.negative;
    expStatus[6] = refState.flags.carry;
    axiRead(StatusAddr, data, resp);
    expectValue($sformatf("%s status", name), data, expStatus);
    dutMem = refState.mem;
  endtask

  task automatic readMemByte(input logic [7:0] addr, input logic [7:0] exp, input string what);
    logic [31:0] data;
    logic [1:0] resp;
    axiRead(MemBase + 12'(addr), data, resp);
    expectResp($sformatf("%s read", what), resp, RespOkay);
    expectValue(what, data, {24'd0, exp});
  endtask

  task automatic testAluPrograms();
    opcode_t aluOps [8];
    opcode_t op;
    bit flagUpd;
    aluOps = '{opAdd, opSub, opAnd, opOrr, opXor, opNot, opLsl, opLsr};
    for (int rep = 0; rep < 8; rep++) begin
      newImage();
      for (int r = 0; r < 4; r++) begin
        emit(encImm(opMovl, 2'(r), 8'($urandom)));
      end
      for (int k = 0; k < 8; k++) begin
        op = aluOps[(k + rep) % 8];
        // Last operation always sets the flags
        flagUpd = (k == 7) ? 1'b1 : 1'($urandom);
        emit(encAlu(op, flagUpd, 2'($urandom), 2'($urandom), 2'($urandom)));
      end
      emit(encImm(opHlt, 2'd0, 8'h00));
      loadImage();
      startRun();
      waitHalted();
      checkState($sformatf("ALU program %0d", rep));
    end
  endtask

  task automatic testStoreLoad();
    logic [7:0] addrA;
    logic [7:0] addrB;
    addrA = 8'h80 + 8'($urandom % 60);
    addrB = 8'hc0 + 8'($urandom % 62);
    newImage();
    for (int r = 0; r < 4; r++) begin
      emit(encImm(opMovl, 2'(r), 8'($urandom)));
    end
    emit(encAlu(opAdd, 1'b1, 2'd2, 2'd0, 2'd1));
    emit(encImm(opSt, 2'd0, addrA));
    emit(encImm(opSt, 2'd1, addrA + 8'd1));
    // R4 picks up R1 low and R2 low as one word
    emit(encImm(opLd, 2'd3, addrA));
    emit(encImm(opSt, 2'd3, addrB));
    emit(encImm(opLd, 2'd2, addrB));
    emit(encImm(opHlt, 2'd0, 8'h00));
    loadImage();
    startRun();
    waitHalted();
    checkState("store/load");
    readMemByte(addrA, refState.mem[addrA], "memory at A");
    readMemByte(addrA + 8'd1, refState.mem[addrA + 8'd1], "memory at A+1");
    readMemByte(addrA + 8'd2, refState.mem[addrA + 8'd2], "memory at A+2");
    readMemByte(addrB, refState.regs[3][7:0], "low byte of R4 at B");
    readMemByte(addrB + 8'd1, refState.regs[3][15:8], "high byte of R4 at B+1");
  endtask

  task automatic testBranches();
    logic [7:0] valA;
    for (int pass = 0; pass < 2; pass++) begin
      valA = 8'($urandom);
      newImage();
      emit(encImm(opMovl, 2'd0, valA));
      emit(encImm(opMovl, 2'd1, (pass == 0) ? valA : valA + 8'd1));
      emit(encImm(opMovl, 2'd2, 8'h00));
      emit(encImm(opMovl, 2'd3, 8'h00));
      emit(encAlu(opSub, 1'b1, 2'd0, 2'd0, 2'd1));
      emit(encImm(opBeq, 2'd0, 8'd14));
      emit(encImm(opMovl, 2'd2, 8'h11));
      emit(encImm(opBne, 2'd0, 8'd18));
      emit(encImm(opMovl, 2'd3, 8'h22));
      emit(encImm(opBra, 2'd0, 8'd22));
      emit(encImm(opMovl, 2'd2, 8'h33));
      emit(encImm(opHlt, 2'd0, 8'h00));
      loadImage();
      startRun();
      waitHalted();
      checkState((pass == 0) ? "branch on zero" : "branch on nonzero");
    end
  endtask

  task automatic testBusyRefusal();
    logic [31:0] data;
    logic [1:0] resp;
    newImage();
    emit(encImm(opMovl, 2'd0, 8'd40));
    emit(encImm(opMovl, 2'd1, 8'd1));
    emit(encImm(opMovl, 2'd2, 8'h00));
    emit(encImm(opMovl, 2'd3, 8'h00));
    // Countdown loop keeps the core busy for a few hundred cycles
    emit(encAlu(opSub, 1'b1, 2'd0, 2'd0, 2'd1));
    emit(encImm(opBne, 2'd0, 8'd8));
    emit(encImm(opHlt, 2'd0, 8'h00));
    loadImage();
    startRun();
    axiRead(StatusAddr, data, resp);
    expectValue("busy bit during run", {31'd0, data[0]}, 32'd1);
    axiWrite(MemBase + 12'hf0, {24'd0, ~image[8'hf0]}, resp);
    expectResp("memory write while busy", resp, RespSlvErr);
    axiWrite(CtrlAddr, 32'h1, resp);
    expectResp("start while busy", resp, RespSlvErr);
    waitHalted();
    checkState("busy refusal");
    readMemByte(8'hf0, refState.mem[8'hf0], "memory after refused write");
    axiRead(12'h008, data, resp);
    expectResp("read of unmapped 0x008", resp, RespSlvErr);
    axiRead(12'h200, data, resp);
    expectResp("read of unmapped 0x200", resp, RespSlvErr);
    axiWrite(12'h00c, 32'h1, resp);
    expectResp("write to unmapped 0x00C", resp, RespSlvErr);
  endtask

  initial begin : mainSequence
    logic [31:0] data;
    logic [1:0] resp;
    void'($urandom(32'h4cc9_5433));
    memKnown = 1'b0;
    checkCount = 0;
    valueErrors = 0;
    protoErrors = 0;
    axiReq <= '0;
    rstN <= 1'b0;
    repeat (16) @(posedge Clock);
    rstN <= 1'b1;

    axiRead(StatusAddr, data, resp);
    expectResp("status read after reset", resp, RespOkay);
    expectValue("status after reset", data, 32'd0);
    for (int r = 0; r < 4; r++) begin
      axiRead(RegBase + 12'(4 * r), data, resp);
      expectValue($sformatf("R%0d after reset", r + 1), data, 32'd0);
    end

    testAluPrograms();
    testStoreLoad();
    testBranches();
    testBusyRefusal();
    drainChecks();

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checkCount, valueErrors, protoErrors);
    if (valueErrors == 0 && protoErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
source/cpuPkg.sv
source/aluUnit.sv
source/byteMemory.sv
source/registerFile.sv
source/sequenceController.sv
source/hostConfigRegs.sv
source/cpuTop.sv
verif/hostBus_assertions.sv
verif/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module cpuTb -Mdir obj_dir -o cpuTbSim

./obj_dir/cpuTbSim | tee sim.log

grep -q "^Done: no errors$" sim.log
echo "Simulation passed"
